// ==== files.f ====
design/aes_pkg.sv
design/aes_if.sv
design/aes_cmd_decode.sv
design/aes_key_schedule.sv
design/aes_round_engine.sv
design/aes_result_stage.sv
design/aes_top.sv
tb/aes_tb.sv

// ==== Makefile ====
TOP := aes_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// ==== tb/aes_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_tb
  import aes_pkg::*;
();

  localparam int SEED           = 52531;
  localparam int RT_COUNT       = 20;
  localparam int NUM_CMDS       = 4 + 2 * RT_COUNT;
  localparam int TIMEOUT_CYCLES = 40 * NUM_CMDS + 200;
  localparam int STALL_CYCLES   = 100;

  // FIPS-197 Appendix B and C.1
  localparam block_t KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam block_t PT_B  = 128'h3243f6a8885a308d313198a2e0370734;
  localparam block_t CT_B  = 128'h3925841d02dc09fbdc118597196a0b32;
  localparam block_t KEY_C = 128'h000102030405060708090a0b0c0d0e0f;
  localparam block_t PT_C  = 128'h00112233445566778899aabbccddeeff;
  localparam block_t CT_C  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  logic   clk_in;
  logic   rst_in;
  logic   cmd_valid;
  logic   cmd_decrypt;
  block_t cmd_block;
  block_t cmd_key;
  logic   cmd_credit;
  logic   res_valid;
  block_t res_block;
  logic   res_credit;

  int     sent_cnt;
  int     returned_cnt;   // Command credits given back by the DUT
  int     rcv_cnt;
  int     outstanding;    // Results held by the sink, not yet credited
  int     cycle_cnt;
  int     value_errs;
  int     proto_errs;
  int     other_errs;
  bit     stall_credits;  // Sink withholds all credits while set
  block_t exp_q [$];
  bit     chk_q [$];      // Clear for round-trip ciphertexts, which are captured instead
  block_t ct_q  [$];
  block_t rt_pt  [RT_COUNT];
  block_t rt_key [RT_COUNT];

  aes_top u_dut (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .cmd_valid   (cmd_valid),
    .cmd_decrypt (cmd_decrypt),
    .cmd_block   (cmd_block),
    .cmd_key     (cmd_key),
    .cmd_credit  (cmd_credit),
    .res_valid   (res_valid),
    .res_block   (res_block),
    .res_credit  (res_credit)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  // ------------------------------------------------------------
  // Upstream and sink models
  // ------------------------------------------------------------

  task automatic send_cmd(input logic dec, input block_t blk, input block_t key,
                          input block_t exp_blk, input bit chk);
    while (sent_cnt - returned_cnt >= CMD_CREDITS) begin
      @(posedge clk_in);
      #1;
    end
    exp_q.push_back(exp_blk);
    chk_q.push_back(chk);
    cmd_valid   = 1'b1;
    cmd_decrypt = dec;
    cmd_block   = blk;
    cmd_key     = key;
    sent_cnt++;
    @(posedge clk_in);
    #1 cmd_valid = 1'b0;
  endtask

  task automatic wait_results();
    while (rcv_cnt != sent_cnt) begin
      @(posedge clk_in);
      #1;
    end
  endtask

  always @(posedge clk_in) begin
    if (rst_in) begin
      returned_cnt <= 0;
      outstanding  <= 0;
    end else begin
      returned_cnt <= returned_cnt + int'(cmd_credit);
      outstanding  <= outstanding + int'(res_valid) - int'(res_credit);
    end
  end

  // One credit back per drained result, after 0 to 6 cycles
  initial begin
    int delay;
    res_credit = 1'b0;
    forever begin
      @(posedge clk_in);
      #1 res_credit = 1'b0;
      if (!rst_in && !stall_credits && outstanding > 0) begin
        delay = $urandom_range(6, 0);
        repeat (delay) begin
          @(posedge clk_in);
          #1;
        end
        res_credit = 1'b1;
      end
    end
  end

  // Once the known-answer results are in, the sink fills up and the DUT runs dry of credits
  initial begin
    stall_credits = 1'b0;
    wait (rcv_cnt == 4);
    stall_credits = 1'b1;
    repeat (STALL_CYCLES) @(posedge clk_in);
    stall_credits = 1'b0;
  end

  always @(posedge clk_in) begin
    block_t exp_blk;
    bit     exp_chk;
    if (!rst_in && res_valid) begin
      rcv_cnt++;
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("Error at %0t: result arrived with no command outstanding", $time);
      end else begin
        exp_blk = exp_q.pop_front();
        exp_chk = chk_q.pop_front();
        if (exp_chk) begin
          assert (res_block == exp_blk)
            else begin
              value_errs++;
              $display("MISMATCH time=%0t res_block expected=%h actual=%h",
                       $time, exp_blk, res_block);
            end
        end else begin
          ct_q.push_back(res_block);
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------

  assert property (@(posedge clk_in) disable iff (rst_in)
                   !(res_valid && outstanding == OUT_CREDITS))
    else begin
      proto_errs++;
      $display("Error at %0t: res_valid raised with the sink full", $time);
    end

  assert property (@(posedge clk_in) disable iff (rst_in) returned_cnt <= sent_cnt)
    else begin
      proto_errs++;
      $display("Error at %0t: more command credits returned than commands sent", $time);
    end

  assert property (@(posedge clk_in) disable iff (rst_in)
                   !(sent_cnt == 0 && (res_valid || cmd_credit)))
    else begin
      proto_errs++;
      $display("Error at %0t: output pulse before any command", $time);
    end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_in);
      cycle_cnt++;
    end
    $display("Timeout: run not finished after %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    rst_in      = 1'b1;
    cmd_valid   = 1'b0;
    cmd_decrypt = 1'b0;
    cmd_block   = '0;
    cmd_key     = '0;
    sent_cnt    = 0;
    rcv_cnt     = 0;
    value_errs  = 0;
    proto_errs  = 0;
    other_errs  = 0;
    void'($urandom(SEED));
    for (int i = 0; i < RT_COUNT; i++) begin
      rt_pt[i]  = {$urandom(), $urandom(), $urandom(), $urandom()};
      rt_key[i] = {$urandom(), $urandom(), $urandom(), $urandom()};
    end

    repeat (16) @(posedge clk_in);
    #1 rst_in = 1'b0;
    repeat (10) @(posedge clk_in);  // Quiet window after reset
    #1;

    send_cmd(1'b0, PT_C, KEY_C, CT_C, 1'b1);
    send_cmd(1'b0, PT_B, KEY_B, CT_B, 1'b1);
    send_cmd(1'b1, CT_C, KEY_C, PT_C, 1'b1);
    send_cmd(1'b1, CT_B, KEY_B, PT_B, 1'b1);

    for (int i = 0; i < RT_COUNT; i++) send_cmd(1'b0, rt_pt[i], rt_key[i], '0, 1'b0);
    wait_results();
    for (int i = 0; i < RT_COUNT; i++) send_cmd(1'b1, ct_q[i], rt_key[i], rt_pt[i], 1'b1);
    wait_results();

    while (outstanding != 0 || returned_cnt != sent_cnt) begin
      @(posedge clk_in);
      #1;
    end
    repeat (8) @(posedge clk_in);

    assert (rcv_cnt == NUM_CMDS && exp_q.size() == 0)
      else begin
        other_errs++;
        $display("Error: %0d results for %0d commands", rcv_cnt, sent_cnt);
      end

    $display("Errors: %0d mismatch, %0d protocol, %0d other",
             value_errs, proto_errs, other_errs);
    if (value_errs + proto_errs + other_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/aes_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_top
  import aes_pkg::*;
(
  input  wire         clk_in,
  input  wire         rst_in,

  // Command stream
  input  wire         cmd_valid,
  input  wire         cmd_decrypt,
  input  wire block_t cmd_block,
  input  wire block_t cmd_key,
  output logic        cmd_credit,

  // Result stream
  output logic        res_valid,
  output block_t      res_block,
  input  wire         res_credit
);

  logic               idle;
  logic               keys_ready;
  logic [ROUND_W-1:0] round_sel;
  block_t             round_key;

  aes_op_if    op_if ();
  aes_block_if blk_if ();

  // ------------------------------------------------------------
  // Decode, execute and result stages
  // ------------------------------------------------------------

  aes_cmd_decode u_decode (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .cmd_valid   (cmd_valid),
    .cmd_decrypt (cmd_decrypt),
    .cmd_block   (cmd_block),
    .cmd_key     (cmd_key),
    .cmd_credit  (cmd_credit),
    .idle        (idle),
    .op          (op_if.source)
  );

  aes_key_schedule u_keys (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .op         (op_if.sink),
    .round_sel  (round_sel),
    .round_key  (round_key),
    .keys_ready (keys_ready)
  );

  aes_round_engine u_engine (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .op         (op_if.sink),
    .keys_ready (keys_ready),
    .round_sel  (round_sel),
    .round_key  (round_key),
    .idle       (idle),
    .res        (blk_if.source)
  );

  aes_result_stage u_result (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .res        (blk_if.sink),
    .res_valid  (res_valid),
    .res_block  (res_block),
    .res_credit (res_credit)
  );

endmodule

`default_nettype wire

// ==== design/aes_result_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_result_stage
  import aes_pkg::*;
(
  input  wire         clk_in,
  input  wire         rst_in,

  aes_block_if.sink   res,

  output logic        res_valid,
  output block_t      res_block,
  input  wire         res_credit
);

  logic                    full;
  block_t                  hold_block;
  logic [OUT_CREDIT_W-1:0] credits;
  logic                    send;

  assign send      = full && (credits != '0);  // Only with a sink slot free
  assign res_valid = send;
  assign res_block = hold_block;
  assign res.free  = !full;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      full    <= 1'b0;
      credits <= OUT_CREDIT_W'(OUT_CREDITS);
    end else begin
      if (res.valid) begin
        full <= 1'b1;
      end else if (send) begin
        full <= 1'b0;
      end

      // A return and a send together leave the count as it is
      case ({res_credit, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (res.valid) hold_block <= res.block;
  end

endmodule

`default_nettype wire

// ==== design/aes_round_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_round_engine
  import aes_pkg::*;
(
  input  wire                clk_in,
  input  wire                rst_in,

  aes_op_if.sink             op,

  input  wire                keys_ready,
  output logic [ROUND_W-1:0] round_sel,
  input  wire block_t        round_key,

  output logic               idle,
  aes_block_if.source        res
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_KEYS,
    ST_ROUND,
    ST_DONE
  } state_t;

  state_t             fsm;
  logic [ROUND_W-1:0] rnd;
  logic               dec_mode;
  block_t             state;
  block_t             enc_tmp;
  block_t             enc_next;
  block_t             dec_tmp;
  block_t             dec_next;

  // ------------------------------------------------------------
  // Whole-state transforms
  // ------------------------------------------------------------

  function automatic block_t sub_bytes(input block_t s);
    block_t o;
    for (int n = 0; n < 16; n++) o[127 - 8*n -: 8] = sub_byte(s[127 - 8*n -: 8]);
    return o;
  endfunction

  function automatic block_t inv_sub_bytes(input block_t s);
    block_t o;
    for (int n = 0; n < 16; n++) o[127 - 8*n -: 8] = inv_sub_byte(s[127 - 8*n -: 8]);
    return o;
  endfunction

  // Row r moves left by r columns
  function automatic block_t shift_rows(input block_t s);
    block_t o;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        o[127 - 8*(r + 4*c) -: 8] = s[127 - 8*(r + 4*((c + r) % 4)) -: 8];
      end
    end
    return o;
  endfunction

  function automatic block_t inv_shift_rows(input block_t s);
    block_t o;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        o[127 - 8*(r + 4*c) -: 8] = s[127 - 8*(r + 4*((c + 4 - r) % 4)) -: 8];
      end
    end
    return o;
  endfunction

  function automatic block_t mix_columns(input block_t s, input logic inverse);
    block_t o;
    for (int c = 0; c < 4; c++) begin
      o[127 - 32*c -: 32] = inverse ? inv_mix_column(s[127 - 32*c -: 32])
                                    : mix_column(s[127 - 32*c -: 32]);
    end
    return o;
  endfunction

  // Decryption walks the key store from the top down
  assign round_sel = dec_mode ? ROUND_W'(NUM_ROUNDS) - rnd : rnd;
  assign idle      = (fsm == ST_IDLE);
  assign res.valid = (fsm == ST_DONE) && res.free;
  assign res.block = state;

  always_comb begin
    enc_tmp = shift_rows(sub_bytes(state));
    if (rnd != ROUND_W'(NUM_ROUNDS)) enc_tmp = mix_columns(enc_tmp, 1'b0);
    enc_next = enc_tmp ^ round_key;

    dec_tmp = inv_sub_bytes(inv_shift_rows(state)) ^ round_key;
    dec_next = (rnd != ROUND_W'(NUM_ROUNDS)) ? mix_columns(dec_tmp, 1'b1) : dec_tmp;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      fsm <= ST_IDLE;
      rnd <= '0;
    end else begin
      case (fsm)
        ST_IDLE:      if (op.valid) fsm <= ST_WAIT_KEYS;
        ST_WAIT_KEYS: if (keys_ready) begin
          fsm <= ST_ROUND;
          rnd <= ROUND_W'(1);
        end
        ST_ROUND: begin
          if (rnd == ROUND_W'(NUM_ROUNDS)) begin
            fsm <= ST_DONE;
            rnd <= '0;
          end else begin
            rnd <= rnd + 1'b1;
          end
        end
        ST_DONE:      if (res.free) fsm <= ST_IDLE;  // Handed to the result buffer
        default:      fsm <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (fsm == ST_IDLE && op.valid) begin
      state    <= op.block;
      dec_mode <= op.decrypt;
    end else if (fsm == ST_WAIT_KEYS && keys_ready) begin
      state <= state ^ round_key;  // Initial key addition
    end else if (fsm == ST_ROUND) begin
      state <= dec_mode ? dec_next : enc_next;
    end
  end

endmodule

`default_nettype wire

// ==== design/aes_key_schedule.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_key_schedule
  import aes_pkg::*;
(
  input  wire                clk_in,
  input  wire                rst_in,

  aes_op_if.sink             op,

  input  wire [ROUND_W-1:0]  round_sel,
  output block_t             round_key,
  output logic               keys_ready
);

  logic               busy;
  logic [ROUND_W-1:0] kround;  // Index of the key written this cycle
  block_t             rk [0:NUM_ROUNDS];
  block_t             prev_key;
  block_t             next_key;

  // One step of the AES-128 expansion, four words at a time
  function automatic block_t expand_key(input block_t k, input logic [ROUND_W-1:0] i);
    logic [31:0] w0, w1, w2, w3;
    logic [31:0] t;
    w0 = k[127:96];
    w1 = k[95:64];
    w2 = k[63:32];
    w3 = k[31:0];
    // RotWord then SubWord on the last word
    t = {sub_byte(w3[23:16]), sub_byte(w3[15:8]), sub_byte(w3[7:0]), sub_byte(w3[31:24])};
    t = t ^ {rcon(i), 24'h000000};
    w0 = w0 ^ t;
    w1 = w1 ^ w0;
    w2 = w2 ^ w1;
    w3 = w3 ^ w2;
    return {w0, w1, w2, w3};
  endfunction

  assign prev_key  = rk[kround - 1'b1];
  assign next_key  = expand_key(prev_key, kround);
  assign round_key = rk[round_sel];  // Combinational read for the engine

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy       <= 1'b0;
      kround     <= '0;
      keys_ready <= 1'b0;
    end else begin
      keys_ready <= 1'b0;
      if (op.valid) begin
        busy   <= 1'b1;
        kround <= ROUND_W'(1);
      end else if (busy) begin
        if (kround == ROUND_W'(NUM_ROUNDS)) begin
          busy       <= 1'b0;
          keys_ready <= 1'b1;  // Key 10 is readable on this pulse
        end else begin
          kround <= kround + 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Round-key store
  // ------------------------------------------------------------

  always_ff @(posedge clk_in) begin
    if (op.valid) begin
      rk[0] <= op.key;
    end else if (busy) begin
      rk[kround] <= next_key;
    end
  end

endmodule

`default_nettype wire

// ==== design/aes_cmd_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_cmd_decode
  import aes_pkg::*;
(
  input  wire         clk_in,
  input  wire         rst_in,

  input  wire         cmd_valid,
  input  wire         cmd_decrypt,
  input  wire block_t cmd_block,
  input  wire block_t cmd_key,
  output logic        cmd_credit,

  input  wire         idle,
  aes_op_if.source    op
);

  logic   slot_full;
  logic   slot_decrypt;
  block_t slot_block;
  block_t slot_key;

  // Launch as soon as the slot holds a command and execution is free
  assign op.valid   = slot_full && idle;
  assign op.decrypt = slot_decrypt;
  assign op.block   = slot_block;
  assign op.key     = slot_key;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      slot_full  <= 1'b0;
      cmd_credit <= 1'b0;
    end else begin
      cmd_credit <= op.valid;  // Slot frees with the launch, credit goes back a cycle later
      if (cmd_valid) begin
        slot_full <= 1'b1;
      end else if (op.valid) begin
        slot_full <= 1'b0;
      end
    end
  end

  // Upstream only sends with a credit in hand, so the slot is empty here
  always_ff @(posedge clk_in) begin
    if (cmd_valid) begin
      slot_decrypt <= cmd_decrypt;
      slot_block   <= cmd_block;
      slot_key     <= cmd_key;
    end
  end

endmodule

`default_nettype wire

// ==== design/aes_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Launch of one command into the execute stage
interface aes_op_if
  import aes_pkg::*;
();
  logic   valid;  // One cycle launch pulse
  logic   decrypt;
  block_t block;
  block_t key;

  modport source (output valid, output decrypt, output block, output key);
  modport sink   (input valid, input decrypt, input block, input key);
endinterface

// Finished block from the round engine to the result buffer
interface aes_block_if
  import aes_pkg::*;
();
  logic   valid;
  block_t block;
  logic   free;  // High while the result buffer is empty

  modport source (output valid, output block, input free);
  modport sink   (input valid, input block, output free);
endinterface

`default_nettype wire

// ==== design/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

  typedef logic [127:0] block_t;  // Byte 0 sits in the top eight bits

  localparam int NUM_ROUNDS   = 10;
  localparam int ROUND_W      = 4;
  localparam int OUT_CREDITS  = 2;
  localparam int OUT_CREDIT_W = 2;
  localparam int CMD_CREDITS  = 1;

  // ------------------------------------------------------------
  // GF(2^8) arithmetic
  // ------------------------------------------------------------

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] x;
    acc = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) acc = acc ^ x;
      x = xtime(x);
    end
    return acc;
  endfunction

  // Inverse as a^254, zero maps to zero
  function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] sq;
    logic [7:0] acc;
    sq = a;
    acc = 8'h01;
    for (int i = 1; i < 8; i++) begin
      sq = gf_mul(sq, sq);
      acc = gf_mul(acc, sq);
    end
    return acc;
  endfunction

  function automatic logic [7:0] rotl8(input logic [7:0] b, input int n);
    return (b << n) | (b >> (8 - n));
  endfunction

  // ------------------------------------------------------------
  // S-boxes
  // ------------------------------------------------------------

  function automatic logic [7:0] sub_byte(input logic [7:0] b);
    logic [7:0] x;
    x = gf_inv(b);
    return x ^ rotl8(x, 1) ^ rotl8(x, 2) ^ rotl8(x, 3) ^ rotl8(x, 4) ^ 8'h63;
  endfunction

  function automatic logic [7:0] inv_sub_byte(input logic [7:0] b);
    logic [7:0] y;
    y = rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05;  // Undo the affine map first
    return gf_inv(y);
  endfunction

  // ------------------------------------------------------------
  // Column mixing, row 0 in the top byte of the column
  // ------------------------------------------------------------

  function automatic logic [31:0] mix_column(input logic [31:0] col);
    logic [7:0] a0, a1, a2, a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  function automatic logic [31:0] inv_mix_column(input logic [31:0] col);
    logic [7:0] a0, a1, a2, a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^ gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09),
            gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^ gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d),
            gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^ gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b),
            gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^ gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e)};
  endfunction

  // Round constant for key expansion round i (1 to 10)
  function automatic logic [7:0] rcon(input logic [ROUND_W-1:0] i);
    case (i)
      4'd1:    return 8'h01;
      4'd2:    return 8'h02;
      4'd3:    return 8'h04;
      4'd4:    return 8'h08;
      4'd5:    return 8'h10;
      4'd6:    return 8'h20;
      4'd7:    return 8'h40;
      4'd8:    return 8'h80;
      4'd9:    return 8'h1b;
      4'd10:   return 8'h36;
      default: return 8'h00;
    endcase
  endfunction

endpackage

`default_nettype wire
